// File: src/pcq_pkg.sv
/*
 * Shared types and constants for the debug/perfmon node of the slow SPR ring.
 * Holds the ring transaction layout, the CESR and THRCTL register layouts,
 * the union that decodes one data word as either SPR, and the SPR numbers
 * this node answers to. Thread fields are sized for the widest core, and
 * modules use only the low THREADS bits.
 */
package pcq_pkg;

   localparam int RING_DATA_WIDTH = 64;
   localparam int SPR_ADDR_WIDTH  = 10;
   localparam int MAX_THREADS     = 4;

   localparam logic [SPR_ADDR_WIDTH-1:0] CESR_ADDR   = 10'd912;
   localparam logic [SPR_ADDR_WIDTH-1:0] THRCTL_ADDR = 10'd916;

   localparam int CESR_RSVD_WIDTH   = RING_DATA_WIDTH - 7 - MAX_THREADS;
   localparam int THRCTL_RSVD_WIDTH = RING_DATA_WIDTH - 3 * MAX_THREADS;

   // One slot on the ring, rw set means read
   typedef struct packed {
      logic                       val;
      logic                       rw;
      logic [1:0]                 etid;
      logic [SPR_ADDR_WIDTH-1:0]  addr;
      logic [RING_DATA_WIDTH-1:0] data;
      logic                       done;
   } slowspr_t;

   // Fields listed from the top of the word down to bit 0
   typedef struct packed {
      logic [CESR_RSVD_WIDTH-1:0] reserved;
      logic [MAX_THREADS-1:0]     pmae;
      logic                       instr_trace_tid;
      logic                       instr_trace_mode;
      logic [2:0]                 count_mode;
      logic                       trace_bus_enable;
      logic                       event_bus_enable;
   } cesr_t;

   // Running is reported by the core and ignored on writes
   typedef struct packed {
      logic [THRCTL_RSVD_WIDTH-1:0] reserved;
      logic [MAX_THREADS-1:0]       running;
      logic [MAX_THREADS-1:0]       step;
      logic [MAX_THREADS-1:0]       stop;
   } thrctl_t;

   typedef union packed {
      cesr_t   cesr;
      thrctl_t thrctl;
   } spr_word_u;

   // Slot as held in the pipeline, with the address match already made
   typedef struct packed {
      slowspr_t slot;
      logic     hit_cesr;
      logic     hit_thrctl;
   } spr_op_t;

endpackage

// File: src/pcq_spr_decode.sv
/*
 * Input stage of the SPR node. Samples the ring slot every cycle and
 * matches its address against CESR and THRCTL. A slot only counts as a
 * hit when it is valid and no earlier node has completed it.
 */
module pcq_spr_decode #(
   parameter int THREADS = 2
) (
   input  logic              nclk,
   input  logic              reset,
   input  pcq_pkg::slowspr_t ring_in,
   output pcq_pkg::spr_op_t  dec_op
);

   import pcq_pkg::*;

   logic     slot_live;
   logic     hit_cesr;
   logic     hit_thrctl;
   logic     val_q;
   logic     hit_cesr_q;
   logic     hit_thrctl_q;
   slowspr_t slot_q;

   if (THREADS < 1 || THREADS > MAX_THREADS) begin : g_threads_range
      $error("THREADS is outside 1 to MAX_THREADS");
   end

   assign slot_live  = ring_in.val & ~ring_in.done;
   assign hit_cesr   = slot_live & (ring_in.addr == CESR_ADDR);
   assign hit_thrctl = slot_live & (ring_in.addr == THRCTL_ADDR);

   always_ff @(posedge nclk) begin
      if (reset) begin
         val_q        <= 1'b0;
         hit_cesr_q   <= 1'b0;
         hit_thrctl_q <= 1'b0;
      end else begin
         val_q        <= ring_in.val;
         hit_cesr_q   <= hit_cesr;
         hit_thrctl_q <= hit_thrctl;
      end
   end

   always_ff @(posedge nclk) begin
      slot_q <= ring_in;
   end

   always_comb begin
      dec_op.slot       = slot_q;
      dec_op.slot.val   = val_q;
      dec_op.hit_cesr   = hit_cesr_q;
      dec_op.hit_thrctl = hit_thrctl_q;
   end

   a_one_hit : assert property (@(posedge nclk) disable iff (reset)
      !(dec_op.hit_cesr && dec_op.hit_thrctl));

endmodule

// File: src/pcq_spr_execute.sv
/*
 * Execute stage of the SPR node. Holds the writable CESR and THRCTL fields,
 * applies ring writes, and lets perfmon alerts and step completion clear
 * their per-thread bits. On a read hit the slot data is replaced by the
 * SPR value; any hit marks the slot done before it moves to the result stage.
 */
module pcq_spr_execute #(
   parameter int THREADS = 2
) (
   input  logic               nclk,
   input  logic               reset,
   input  pcq_pkg::spr_op_t   dec_op,
   input  logic [THREADS-1:0] xu_pc_running,
   input  logic [THREADS-1:0] xu_pc_perfmon_alert,
   input  logic [THREADS-1:0] iu_pc_step_done,
   output pcq_pkg::spr_op_t   exe_op,
   output pcq_pkg::cesr_t     cesr,
   output pcq_pkg::thrctl_t   thrctl
);

   import pcq_pkg::*;

   spr_word_u          wr_word;
   logic               cesr_wr;
   logic               thrctl_wr;
   logic               spr_hit;
   logic [RING_DATA_WIDTH-1:0] rd_data;

   logic               event_bus_enable_q;
   logic               trace_bus_enable_q;
   logic [2:0]         count_mode_q;
   logic               instr_trace_mode_q;
   logic               instr_trace_tid_q;
   logic [THREADS-1:0] pmae_q;
   logic [THREADS-1:0] stop_q;
   logic [THREADS-1:0] step_q;
   logic [THREADS-1:0] pmae_nxt;
   logic [THREADS-1:0] step_nxt;

   // The ring word is read through whichever SPR layout was addressed
   assign wr_word   = dec_op.slot.data;
   assign cesr_wr   = dec_op.hit_cesr & ~dec_op.slot.rw;
   assign thrctl_wr = dec_op.hit_thrctl & ~dec_op.slot.rw;
   assign spr_hit   = dec_op.hit_cesr | dec_op.hit_thrctl;

   // Hardware clears are applied after the write so they win on the same bit
   assign pmae_nxt = (cesr_wr ? wr_word.cesr.pmae[THREADS-1:0] : pmae_q)
                     & ~xu_pc_perfmon_alert;
   assign step_nxt = (thrctl_wr ? wr_word.thrctl.step[THREADS-1:0] : step_q)
                     & ~iu_pc_step_done;

   always_ff @(posedge nclk) begin
      if (reset) begin
         event_bus_enable_q <= 1'b0;
         trace_bus_enable_q <= 1'b0;
         count_mode_q       <= 3'b000;
         instr_trace_mode_q <= 1'b0;
         instr_trace_tid_q  <= 1'b0;
         pmae_q             <= '0;
         stop_q             <= '0;
         step_q             <= '0;
      end else begin
         if (cesr_wr) begin
            event_bus_enable_q <= wr_word.cesr.event_bus_enable;
            trace_bus_enable_q <= wr_word.cesr.trace_bus_enable;
            count_mode_q       <= wr_word.cesr.count_mode;
            instr_trace_mode_q <= wr_word.cesr.instr_trace_mode;
            instr_trace_tid_q  <= wr_word.cesr.instr_trace_tid;
         end
         if (thrctl_wr) begin
            stop_q <= wr_word.thrctl.stop[THREADS-1:0];
         end
         pmae_q <= pmae_nxt;
         step_q <= step_nxt;
      end
   end

   // Register views, with reserved and unused thread bits held at zero
   always_comb begin
      cesr                      = '0;
      cesr.event_bus_enable     = event_bus_enable_q;
      cesr.trace_bus_enable     = trace_bus_enable_q;
      cesr.count_mode           = count_mode_q;
      cesr.instr_trace_mode     = instr_trace_mode_q;
      cesr.instr_trace_tid      = instr_trace_tid_q;
      cesr.pmae[THREADS-1:0]    = pmae_q;
   end

   always_comb begin
      thrctl                      = '0;
      thrctl.stop[THREADS-1:0]    = stop_q;
      thrctl.step[THREADS-1:0]    = step_q;
      thrctl.running[THREADS-1:0] = xu_pc_running;
   end

   assign rd_data = dec_op.hit_cesr ? RING_DATA_WIDTH'(cesr) : RING_DATA_WIDTH'(thrctl);

   always_comb begin
      exe_op = dec_op;
      if (spr_hit) begin
         exe_op.slot.done = 1'b1;
         if (dec_op.slot.rw) begin
            exe_op.slot.data = rd_data;
         end
      end
   end

   a_thread_bits : assert property (@(posedge nclk) disable iff (reset)
      ((cesr.pmae >> THREADS) == '0) &&
      ((thrctl.stop >> THREADS) == '0) &&
      ((thrctl.step >> THREADS) == '0));

endmodule

// File: src/pcq_spr_result.sv
/*
 * Result stage of the SPR node. Registers the slot coming out of execute
 * and drives it onto the ring toward the next node. The match flags are
 * local to this node and do not travel on.
 */
module pcq_spr_result (
   input  logic              nclk,
   input  logic              reset,
   input  pcq_pkg::spr_op_t  exe_op,
   output pcq_pkg::slowspr_t ring_out
);

   import pcq_pkg::*;

   logic     val_q;
   slowspr_t slot_q;
   logic     passed_done;

   always_ff @(posedge nclk) begin
      if (reset) begin
         val_q <= 1'b0;
      end else begin
         val_q <= exe_op.slot.val;
      end
   end

   always_ff @(posedge nclk) begin
      slot_q <= exe_op.slot;
   end

   always_comb begin
      ring_out     = slot_q;
      ring_out.val = val_q;
   end

   // Done without a local hit means an earlier node completed the slot
   assign passed_done = exe_op.slot.val & exe_op.slot.done &
                        ~exe_op.hit_cesr & ~exe_op.hit_thrctl;

   a_done_passes : assert property (@(posedge nclk) disable iff (reset)
      passed_done |=> (ring_out.val && ring_out.done &&
                       ring_out.data == $past(exe_op.slot.data)));

endmodule

// File: src/pcq_spr.sv
/*
 * Debug and performance-monitor node of the slow SPR ring. A slot passes
 * decode, execute and result stages and leaves two cycles after it was
 * sampled. CESR drives the trace, event and pmae controls and THRCTL drives
 * the stop and step requests toward the instruction unit.
 */
module pcq_spr #(
   parameter int THREADS = 2
) (
   input  logic               nclk,
   input  logic               reset,
   input  pcq_pkg::slowspr_t  ring_in,
   output pcq_pkg::slowspr_t  ring_out,

   input  logic [THREADS-1:0] xu_pc_running,
   input  logic [THREADS-1:0] xu_pc_perfmon_alert,
   input  logic [THREADS-1:0] iu_pc_step_done,

   output logic               trace_bus_enable,
   output logic               event_bus_enable,
   output logic [2:0]         event_count_mode,
   output logic               instr_trace_mode,
   output logic               instr_trace_tid,

   output logic [THREADS-1:0] pc_xu_spr_cesr1_pmae,
   output logic [THREADS-1:0] pc_iu_stop,
   output logic [THREADS-1:0] pc_iu_step
);

   import pcq_pkg::*;

   spr_op_t dec_op;
   spr_op_t exe_op;
   cesr_t   cesr;
   thrctl_t thrctl;

   pcq_spr_decode #(.THREADS(THREADS)) pcq_spr_decode (
      .nclk(nclk),
      .reset(reset),
      .ring_in(ring_in),
      .dec_op(dec_op)
   );

   pcq_spr_execute #(.THREADS(THREADS)) pcq_spr_execute (
      .nclk(nclk),
      .reset(reset),
      .dec_op(dec_op),
      .xu_pc_running(xu_pc_running),
      .xu_pc_perfmon_alert(xu_pc_perfmon_alert),
      .iu_pc_step_done(iu_pc_step_done),
      .exe_op(exe_op),
      .cesr(cesr),
      .thrctl(thrctl)
   );

   pcq_spr_result pcq_spr_result (
      .nclk(nclk),
      .reset(reset),
      .exe_op(exe_op),
      .ring_out(ring_out)
   );

   assign trace_bus_enable     = cesr.trace_bus_enable;
   assign event_bus_enable     = cesr.event_bus_enable;
   assign event_count_mode     = cesr.count_mode;
   assign instr_trace_mode     = cesr.instr_trace_mode;
   assign instr_trace_tid      = cesr.instr_trace_tid;
   assign pc_xu_spr_cesr1_pmae = cesr.pmae[THREADS-1:0];
   assign pc_iu_stop           = thrctl.stop[THREADS-1:0];
   assign pc_iu_step           = thrctl.step[THREADS-1:0];

endmodule

// File: test/pcq_spr_tb_table.svh
/*
 * Stimulus and expected values for the SPR node testbench, included in the
 * testbench module. Each row drives one ring slot with its thread inputs and
 * gives the slot expected on ring_out and the control outputs that follow.
 */
`ifndef PCQ_SPR_TB_TABLE_SVH
`define PCQ_SPR_TB_TABLE_SVH

typedef struct packed {
   logic [1:0] running;
   logic [1:0] perfmon_alert;
   logic [1:0] step_done;
} thr_t;

typedef struct packed {
   logic       trace_bus_enable;
   logic       event_bus_enable;
   logic [2:0] count_mode;
   logic       instr_trace_mode;
   logic       instr_trace_tid;
   logic [1:0] pmae;
   logic [1:0] stop;
   logic [1:0] step;
} ctrl_t;

// With back_to_back set the next row enters on the very next cycle
typedef struct packed {
   logic [8*16-1:0] name;
   logic            back_to_back;
   thr_t            thr;
   slowspr_t        slot;
   slowspr_t        exp_ring;
   ctrl_t           exp_ctrl;
} row_t;

localparam int ROW_COUNT = 11;

// Columns: name, back_to_back, {running, alert, step_done}, slot {val, rw, etid, addr,
// data, done}, expected slot, expected {trace, event, count, itrace mode/tid, pmae, stop, step}
localparam row_t ROWS [ROW_COUNT] = '{
   '{"reset_cesr_rd", 1'b0, '{2'b00, 2'b00, 2'b00},
     '{1'b1, 1'b1, 2'd0, CESR_ADDR, 64'hdead_beef_0000_1234, 1'b0},
     '{1'b1, 1'b1, 2'd0, CESR_ADDR, 64'h0, 1'b1},
     '{1'b0, 1'b0, 3'b000, 1'b0, 1'b0, 2'b00, 2'b00, 2'b00}},
   // Reserved bits and pmae bits of threads 2 and 3 are written but do not stick
   '{"cesr_write", 1'b0, '{2'b00, 2'b00, 2'b00},
     '{1'b1, 1'b0, 2'd1, CESR_ADDR, 64'hffff_0000_0000_07f7, 1'b0},
     '{1'b1, 1'b0, 2'd1, CESR_ADDR, 64'hffff_0000_0000_07f7, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b00, 2'b00}},
   '{"cesr_read", 1'b0, '{2'b00, 2'b00, 2'b00},
     '{1'b1, 1'b1, 2'd2, CESR_ADDR, 64'h5555_5555_5555_5555, 1'b0},
     '{1'b1, 1'b1, 2'd2, CESR_ADDR, 64'h0000_0000_0000_01f7, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b00, 2'b00}},
   '{"foreign_addr", 1'b0, '{2'b00, 2'b00, 2'b00},
     '{1'b1, 1'b0, 2'd0, 10'd913, 64'h0123_4567_89ab_cdef, 1'b0},
     '{1'b1, 1'b0, 2'd0, 10'd913, 64'h0123_4567_89ab_cdef, 1'b0},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b00, 2'b00}},
   // A write of zero that an earlier node already completed must not clear CESR
   '{"done_passthru", 1'b0, '{2'b00, 2'b00, 2'b00},
     '{1'b1, 1'b0, 2'd3, CESR_ADDR, 64'h0, 1'b1},
     '{1'b1, 1'b0, 2'd3, CESR_ADDR, 64'h0, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b00, 2'b00}},
   '{"thrctl_write", 1'b0, '{2'b10, 2'b00, 2'b00},
     '{1'b1, 1'b0, 2'd0, THRCTL_ADDR, 64'h8000_0000_0000_0ff5, 1'b0},
     '{1'b1, 1'b0, 2'd0, THRCTL_ADDR, 64'h8000_0000_0000_0ff5, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b01, 2'b11}},
   '{"step_done_t0", 1'b0, '{2'b10, 2'b00, 2'b01},
     '{1'b0, 1'b0, 2'd0, 10'd0, 64'h0, 1'b0},
     '{1'b0, 1'b0, 2'd0, 10'd0, 64'h0, 1'b0},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b01, 2'b10}},
   '{"thrctl_read", 1'b0, '{2'b10, 2'b00, 2'b00},
     '{1'b1, 1'b1, 2'd1, THRCTL_ADDR, 64'hffff_ffff_ffff_ffff, 1'b0},
     '{1'b1, 1'b1, 2'd1, THRCTL_ADDR, 64'h0000_0000_0000_0221, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b11, 2'b01, 2'b10}},
   '{"alert_t1", 1'b0, '{2'b10, 2'b10, 2'b00},
     '{1'b0, 1'b0, 2'd0, 10'd0, 64'h0, 1'b0},
     '{1'b0, 1'b0, 2'd0, 10'd0, 64'h0, 1'b0},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b01, 2'b01, 2'b10}},
   '{"b2b_thrctl_wr", 1'b1, '{2'b10, 2'b00, 2'b00},
     '{1'b1, 1'b0, 2'd2, THRCTL_ADDR, 64'h0000_0000_0000_0012, 1'b0},
     '{1'b1, 1'b0, 2'd2, THRCTL_ADDR, 64'h0000_0000_0000_0012, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b01, 2'b10, 2'b01}},
   '{"b2b_thrctl_rd", 1'b0, '{2'b01, 2'b00, 2'b00},
     '{1'b1, 1'b1, 2'd3, THRCTL_ADDR, 64'h0, 1'b0},
     '{1'b1, 1'b1, 2'd3, THRCTL_ADDR, 64'h0000_0000_0000_0112, 1'b1},
     '{1'b1, 1'b1, 3'b101, 1'b1, 1'b1, 2'b01, 2'b10, 2'b01}}
};

`endif

// File: test/pcq_spr_tb.sv
/*
 * Testbench for the SPR ring node. Applies the table rows as ring slots,
 * checks each slot on ring_out two cycles after it was sampled and the
 * control outputs one cycle later, then prints a summary of the run.
 */
module pcq_spr_tb;

   import pcq_pkg::*;

   `include "pcq_spr_tb_table.svh"

   localparam int THREADS = 2;

   logic     nclk;
   logic     reset;
   slowspr_t ring_in;
   slowspr_t ring_out;
   thr_t     thr;
   wire      ctrl_t ctrl;
   int       errors;
   int       checks;
   int       cycle_count;
   int       issue_cycle [ROW_COUNT];

   pcq_spr #(.THREADS(THREADS)) dut (
      .nclk(nclk),
      .reset(reset),
      .ring_in(ring_in),
      .ring_out(ring_out),
      .xu_pc_running(thr.running),
      .xu_pc_perfmon_alert(thr.perfmon_alert),
      .iu_pc_step_done(thr.step_done),
      .trace_bus_enable(ctrl.trace_bus_enable),
      .event_bus_enable(ctrl.event_bus_enable),
      .event_count_mode(ctrl.count_mode),
      .instr_trace_mode(ctrl.instr_trace_mode),
      .instr_trace_tid(ctrl.instr_trace_tid),
      .pc_xu_spr_cesr1_pmae(ctrl.pmae),
      .pc_iu_stop(ctrl.stop),
      .pc_iu_step(ctrl.step)
   );

   initial begin
      nclk = 1'b0;
      forever begin
         #20 nclk = ~nclk;
      end
   end

   // Worst case per row is one drive cycle plus five idle cycles
   initial begin
      cycle_count = 0;
      while (cycle_count < ROW_COUNT * 7 + 40) begin
         @(posedge nclk);
         cycle_count++;
      end
      $display("Timeout: the table did not finish within %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
   end

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %0s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   initial begin
      int row;
      int idle_left;
      int finished;
      int cyc;

      void'($urandom(32'hd4e3b90a));
      errors  = 0;
      checks  = 0;
      reset   = 1'b1;
      thr     = '0;
      // A live CESR write sits on the ring during reset and must not take effect
      ring_in      = '0;
      ring_in.val  = 1'b1;
      ring_in.addr = CESR_ADDR;
      ring_in.data = '1;

      repeat (10) @(posedge nclk);
      reset   <= 1'b0;
      ring_in <= '0;
      @(negedge nclk);
      check_value("reset_ring_val", 128'(1'b0), 128'(ring_out.val));

      row       = 0;
      idle_left = 0;
      finished  = 0;
      cyc       = 0;
      while (finished < ROW_COUNT) begin
         @(posedge nclk);
         cyc++;
         if (row < ROW_COUNT && idle_left == 0) begin
            ring_in <= ROWS[row].slot;
            thr     <= ROWS[row].thr;
            issue_cycle[row] = cyc;
            // Two idle cycles keep one row's effects apart from the next row
            idle_left = ROWS[row].back_to_back ? 0 : 2 + int'($urandom_range(3, 0));
            row++;
         end else begin
            ring_in           <= '0;
            thr.perfmon_alert <= '0;
            thr.step_done     <= '0;
            if (idle_left > 0) begin
               idle_left--;
            end
         end

         @(negedge nclk);
         for (int r = 0; r < row; r++) begin
            if (cyc == issue_cycle[r] + 2) begin
               check_value($sformatf("%0s ring_out", ROWS[r].name),
                           128'(ROWS[r].exp_ring), 128'(ring_out));
            end
            if (cyc == issue_cycle[r] + 3) begin
               check_value($sformatf("%0s controls", ROWS[r].name),
                           128'(ROWS[r].exp_ctrl), 128'(ctrl));
               finished++;
            end
         end
      end

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+test
src/pcq_pkg.sv
src/pcq_spr_decode.sv
src/pcq_spr_execute.sv
src/pcq_spr_result.sv
src/pcq_spr.sv
test/pcq_spr_tb.sv

// File: Makefile
# Verilator build and run of the SPR ring node testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module pcq_spr_tb -Mdir obj_dir -o pcq_spr_sim

run: compile
	./obj_dir/pcq_spr_sim | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
